/* list.f */
design/proj_readout_pkg.sv
design/bx_sequencer.sv
design/mem_reader.sv
design/stream_merger.sv
design/proj_readout_top.sv
verif/proj_readout_sva.sv
verif/proj_readout_tb.sv

/* verif/proj_readout_golden.txt */
# e <start> <count0 .. count11> <extra_start> opens an event, end closes it
# w <last> <bx> <pair> <slot> <addr> is one expected word, data is image[pair*4+slot][addr]
e 1 2 0 0 1 0 0 0 0 0 0 1 0 0
w 0 0 0 0 0
w 0 0 0 0 1
w 0 0 0 3 0
w 1 0 2 2 0
end
e 1 0 0 0 0 0 0 0 0 0 0 0 0 1
end
e 1 0 3 0 0 1 0 0 2 0 0 0 0 1
w 0 2 0 1 0
w 0 2 0 1 1
w 0 2 0 1 2
w 0 2 1 0 0
w 0 2 1 3 0
w 1 2 1 3 1
end
e 0 0 0 0 0 0 0 0 0 0 0 0 0 0
end
e 1 0 0 1 0 1 0 0 1 0 1 0 0 0
w 0 3 0 2 0
w 0 3 1 0 0
w 0 3 1 3 0
w 1 3 2 1 0
end
e 1 0 0 0 0 0 0 0 0 0 0 0 5 1
w 0 4 2 3 0
w 0 4 2 3 1
w 0 4 2 3 2
w 0 4 2 3 3
w 1 4 2 3 4
end

/* verif/proj_readout_tb.sv */
module proj_readout_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import proj_readout_pkg::*;

    localparam int N_MEM   = 12;
    localparam int TIMEOUT = 400;    // cycles allowed for any single wait
    localparam int QUIET   = 4;      // idle cycles checked after done
    localparam int GAP     = 10;     // idle cycles for an event line without start

    logic       clk;
    logic       rst;
    logic       event_start;
    count_t     item_count [N_MEM];
    proj_word_t mem_data   [N_MEM];
    logic       out_ack;
    mem_rd_t    mem_rd     [N_MEM];
    proj_out_t  out_word;
    logic       out_req;
    logic       done;

    logic [PROJ_W-1:0] image [N_MEM][MEM_DEPTH];   // memory contents
    mem_rd_t           rd_q  [N_MEM];              // request seen at the last posedge
    logic [15:0]       lfsr;                       // shared random source
    int                value_errors;
    int                timeout_errors;
    int                other_errors;
    int                assert_errors;              // bound assertion failures
    logic              timed_out;                  // stops the golden walk
    int                fd;
    int                code;
    logic [63:0]       tag;                        // first token of a golden line
    logic [8*160-1:0]  line;
    int                ev_start;
    int                ev_extra;
    int                cnt [N_MEM];
    int                w_last;
    int                w_bx;
    int                w_pair;
    int                w_slot;
    int                w_addr;
    logic              started;                    // event line pulsed event_start

    proj_readout_top #(.N_MEM(N_MEM)) UUT (
        .clk(clk),
        .rst(rst),
        .event_start(event_start),
        .item_count(item_count),
        .mem_data(mem_data),
        .out_ack(out_ack),
        .mem_rd(mem_rd),
        .out_word(out_word),
        .out_req(out_req),
        .done(done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                     // 8 ns period
    end

    //////////////////////////////////////////////////////////////////////
    // memory models answering one cycle after en
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        for (int k = 0; k < N_MEM; k++) begin
            rd_q[k] <= mem_rd[k];
        end
    end

    always @(negedge clk) begin
        for (int k = 0; k < N_MEM; k++) begin
            if (rd_q[k].en === 1'b1) begin
                mem_data[k] = image[k][rd_q[k].addr];   // ready before the capture edge
            end
        end
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // x^16+x^14+x^13+x^11
    endfunction

    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[62:0], lfsr[0]};             // one step per bit
        end
    endtask

    task automatic fill_images();
        logic [63:0] v;
        for (int k = 0; k < N_MEM; k++) begin
            for (int a = 0; a < MEM_DEPTH; a++) begin
                take_bits(PROJ_W, v);
                image[k][a] = v[PROJ_W-1:0];
            end
        end
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        value_errors++;
        $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, act);
    endtask

    task automatic note_timeout(input string what);
        timeout_errors++;
        timed_out = 1'b1;
        $display("timeout after %0d cycles waiting for %s at %0t ns", TIMEOUT, what, $time);
    endtask

    task automatic check_reset_state();
        logic any_en;
        any_en = 1'b0;
        for (int k = 0; k < N_MEM; k++) begin
            if (mem_rd[k].en !== 1'b0) any_en = 1'b1;
        end
        assert (out_req === 1'b0) else report_mismatch("out_req", 0, out_req);
        assert (done === 1'b0) else report_mismatch("done", 0, done);
        assert (any_en === 1'b0) else report_mismatch("mem_rd.en", 0, any_en);
    endtask

    task automatic check_quiet(input int n);
        repeat (n) begin
            @(negedge clk);
            assert (out_req === 1'b0) else report_mismatch("out_req", 0, out_req);
            assert (done === 1'b0) else report_mismatch("done", 0, done);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // golden file steps
    //////////////////////////////////////////////////////////////////////

    task automatic read_event_line();
        code = $fscanf(fd, "%d", ev_start);
        for (int k = 0; k < N_MEM; k++) begin
            code = $fscanf(fd, "%d", cnt[k]);
        end
        code = $fscanf(fd, "%d", ev_extra);
    endtask

    task automatic begin_event();
        @(negedge clk);
        for (int k = 0; k < N_MEM; k++) begin
            item_count[k] = count_t'(cnt[k]);      // held until the next event line
        end
        started = (ev_start != 0);
        if (started) begin
            event_start = 1'b1;
            @(negedge clk);
            event_start = (ev_extra != 0);         // second start lands while busy
            if (ev_extra != 0) begin
                @(negedge clk);
                event_start = 1'b0;
            end
        end
    endtask

    task automatic expect_word();
        proj_out_t   exp;
        int          idx;
        int          cycles;
        logic [63:0] dly;
        if (timed_out) return;
        idx       = w_pair * SLOTS_PER_PAIR + w_slot;
        exp.last  = w_last[0];
        exp.bx    = w_bx[BX_W-1:0];
        exp.pair  = w_pair[PAIR_W-1:0];
        exp.slot  = w_slot[SLOT_W-1:0];
        exp.spare = '0;
        exp.data  = image[idx][w_addr];
        cycles    = 0;
        while (out_req !== 1'b1 && cycles < TIMEOUT) begin
            assert (done !== 1'b1) else begin
                other_errors++;
                $display("done pulsed at %0t ns with words still expected", $time);
            end
            @(negedge clk);
            cycles++;
        end
        assert (out_req === 1'b1) else note_timeout("out_req");
        if (timed_out) return;
        assert (out_word === exp) else report_mismatch("out_word", exp, out_word);
        take_bits(2, dly);                         // 0 to 3 cycles of back-pressure
        repeat (int'(dly)) @(negedge clk);
        out_ack = 1'b1;
        cycles  = 0;
        while (out_req !== 1'b0 && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        assert (out_req === 1'b0) else note_timeout("out_req to fall");
        out_ack = 1'b0;
    endtask

    task automatic finish_event();
        int cycles;
        if (timed_out) return;
        if (!started) begin
            check_quiet(GAP);                      // nothing may move without a start
            return;
        end
        cycles = 0;
        while (done !== 1'b1 && cycles < TIMEOUT) begin
            assert (out_req !== 1'b1) else begin
                other_errors++;
                $display("out_req raised at %0t ns after the last expected word", $time);
            end
            @(negedge clk);
            cycles++;
        end
        assert (done === 1'b1) else note_timeout("done");
        if (!timed_out) check_quiet(QUIET);        // done is one cycle wide with no stray request
    endtask

    initial begin
        rst            = 1'b1;
        event_start    = 1'b0;
        out_ack        = 1'b0;
        timed_out      = 1'b0;
        started        = 1'b0;
        value_errors   = 0;
        timeout_errors = 0;
        other_errors   = 0;
        assert_errors  = 0;
        lfsr           = 16'd74;
        for (int k = 0; k < N_MEM; k++) begin
            item_count[k] = '0;
            mem_data[k]   = '0;
        end
        fill_images();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_reset_state();
        fd = $fopen("verif/proj_readout_golden.txt", "r");
        assert (fd != 0) else begin
            other_errors++;
            $display("could not open verif/proj_readout_golden.txt");
        end
        if (fd != 0) begin
            while (!timed_out && $fscanf(fd, "%s", tag) == 1) begin
                if (tag == "#") begin
                    code = $fgets(line, fd);       // column notes
                end else if (tag == "e") begin
                    read_event_line();
                    begin_event();
                end else if (tag == "w") begin
                    code = $fscanf(fd, "%d %d %d %d %d", w_last, w_bx, w_pair, w_slot, w_addr);
                    expect_word();
                end else begin
                    assert (tag == "end") else begin
                        other_errors++;
                        $display("unknown token %0s in the golden file", tag);
                    end
                    if (tag == "end") finish_event();
                end
            end
            $fclose(fd);
        end
        assert_errors = UUT.u_sva.fail_count;
        $display("value errors %0d, timeout errors %0d, assertion errors %0d, other errors %0d",
                 value_errors, timeout_errors, assert_errors, other_errors);
        if (value_errors + timeout_errors + assert_errors + other_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* verif/proj_readout_sva.sv */
module proj_readout_sva #(
    parameter int N_MEM = 12                                   // projection memories
) (
    input logic                            clk,
    input logic                            rst,
    input logic                            load,               // event accepted last cycle
    input proj_readout_pkg::count_t        item_count [N_MEM], // counts latched on load
    input logic                            out_req,
    input logic                            out_ack,
    input proj_readout_pkg::proj_out_t     out_word
);
    timeunit 1ns;
    timeprecision 1ps;

    import proj_readout_pkg::*;

    logic counts_in_range;   // every count fits its memory
    int   fail_count = 0;    // failed assertions so far

    always_comb begin
        counts_in_range = 1'b1;
        for (int k = 0; k < N_MEM; k++) begin
            if (item_count[k] > MEM_DEPTH) begin
                counts_in_range = 1'b0;    // readers would wrap the address
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // four-phase output link
    //////////////////////////////////////////////////////////////////////

    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        out_req && !out_ack |=> out_req)
        else begin
            fail_count++;
            $error("out_req dropped before out_ack rose");
        end

    a_req_rise: assert property (@(posedge clk) disable iff (rst)
        !out_req && out_ack |=> !out_req)
        else begin
            fail_count++;
            $error("out_req raised while out_ack was still high");
        end

    a_word_stable: assert property (@(posedge clk) disable iff (rst)
        out_req && $past(out_req) |-> $stable(out_word))
        else begin
            fail_count++;
            $error("out_word changed while out_req was high");
        end

    a_count_range: assert property (@(posedge clk) disable iff (rst)
        load |-> counts_in_range)
        else begin
            fail_count++;
            $error("item_count above memory depth at event start");
        end

endmodule

bind proj_readout_top proj_readout_sva #(
    .N_MEM (N_MEM)
) u_sva (
    .clk        (clk),
    .rst        (rst),
    .load       (load),
    .item_count (item_count),
    .out_req    (out_req),
    .out_ack    (out_ack),
    .out_word   (out_word)
);

/* design/proj_readout_top.sv */
module proj_readout_top #(
    parameter int N_MEM = 12                                      // projection memories
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          event_start,            // start pulse
    input  proj_readout_pkg::count_t      item_count [N_MEM],     // words per memory
    input  proj_readout_pkg::proj_word_t  mem_data   [N_MEM],     // memory read data
    input  logic                          out_ack,                // four-phase ack
    output proj_readout_pkg::mem_rd_t     mem_rd     [N_MEM],     // memory read requests
    output proj_readout_pkg::proj_out_t   out_word,               // merged tagged word
    output logic                          out_req,                // four-phase req
    output logic                          done                    // event complete
);
    import proj_readout_pkg::*;

    logic            load;                  // readout kick
    logic [BX_W-1:0] bx;                    // current event bx
    logic            all_drained_done;      // merger completion
    reader_stat_t    stat     [N_MEM];      // reader flags
    proj_word_t      buf_word [N_MEM];      // reader prefetch buffers
    logic            pop      [N_MEM];      // merger pops

    //////////////////////////////////////////////////////////////////////
    // event control
    //////////////////////////////////////////////////////////////////////

    bx_sequencer u_seq (
        .clk              (clk),
        .rst              (rst),
        .event_start      (event_start),
        .all_drained_done (all_drained_done),
        .load             (load),
        .bx               (bx),
        .done             (done)
    );

    //////////////////////////////////////////////////////////////////////
    // one reader per memory
    //////////////////////////////////////////////////////////////////////

    for (genvar k = 0; k < N_MEM; k++) begin : g_reader
        mem_reader u_reader (
            .clk        (clk),
            .rst        (rst),
            .load       (load),
            .item_count (item_count[k]),
            .mem_rd     (mem_rd[k]),
            .mem_data   (mem_data[k]),
            .pop        (pop[k]),
            .stat       (stat[k]),
            .buf_word   (buf_word[k])
        );
    end

    stream_merger #(
        .N_MEM (N_MEM)
    ) u_merger (
        .clk              (clk),
        .rst              (rst),
        .load             (load),
        .bx               (bx),
        .stat             (stat),
        .buf_word         (buf_word),
        .pop              (pop),
        .out_word         (out_word),
        .out_req          (out_req),
        .out_ack          (out_ack),
        .all_drained_done (all_drained_done)
    );

endmodule

/* design/stream_merger.sv */
module stream_merger #(
    parameter int N_MEM = 12                                   // number of readers
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              load,             // restart at memory 0
    input  logic [proj_readout_pkg::BX_W-1:0] bx,               // bx from the sequencer
    input  proj_readout_pkg::reader_stat_t    stat     [N_MEM], // reader flags
    input  proj_readout_pkg::proj_word_t      buf_word [N_MEM], // reader buffers
    output logic                              pop      [N_MEM], // take buffered word
    output proj_readout_pkg::proj_out_t       out_word,         // tagged output word
    output logic                              out_req,          // four-phase request
    input  logic                              out_ack,          // four-phase acknowledge
    output logic                              all_drained_done  // event finished
);
    import proj_readout_pkg::*;

    localparam int IDX_W = (N_MEM > 1) ? $clog2(N_MEM) : 1;

    typedef enum logic [1:0] {
        S_IDLE,      // waiting for load
        S_SCAN,      // looking at reader idx
        S_REQ,       // out_req high, waiting for ack
        S_ACK_LOW    // out_req low, waiting for ack to drop
    } state_t;

    state_t           state;
    logic [IDX_W-1:0] idx;            // current memory index
    logic [BX_W-1:0]  bx_q;           // bx latched for the event
    logic             last_q;         // word in flight is the event's last
    logic             all_drained;    // every reader is empty
    logic             rest_drained;   // every reader above idx is empty
    logic             take;           // move reader idx's word to the output
    proj_out_t        word_next;      // header plus payload for reader idx

    //////////////////////////////////////////////////////////////////////
    // reader summary
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        all_drained  = 1'b1;
        rest_drained = 1'b1;
        for (int k = 0; k < N_MEM; k++) begin
            if (!stat[k].drained) begin
                all_drained = 1'b0;
                if (k > idx) begin
                    rest_drained = 1'b0;       // more words still to come
                end
            end
        end
    end

    // a new request only starts with ack low, as the handshake demands
    assign take = (state == S_SCAN) && !all_drained && stat[idx].valid && !out_ack;

    always_comb begin
        for (int k = 0; k < N_MEM; k++) begin
            pop[k] = take && (idx == k);       // one-cycle pop to the chosen reader
        end
    end

    //////////////////////////////////////////////////////////////////////
    // header build
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        word_next.last  = stat[idx].is_final && rest_drained;
        word_next.bx    = bx_q;
        word_next.pair  = PAIR_W'(idx / SLOTS_PER_PAIR);   // layer pair
        word_next.slot  = SLOT_W'(idx % SLOTS_PER_PAIR);   // slot within pair
        word_next.spare = '0;
        word_next.data  = buf_word[idx].data;
    end

    // empty event ends in the first scan cycle, otherwise after the last ack
    assign all_drained_done = ((state == S_SCAN) && all_drained) ||
                              ((state == S_ACK_LOW) && !out_ack && last_q);

    //////////////////////////////////////////////////////////////////////
    // control FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= S_IDLE;
            idx     <= '0;
            out_req <= 1'b0;
            last_q  <= 1'b0;
        end else if (load) begin
            state <= S_SCAN;
            idx   <= '0;                              // drain in memory-index order
        end else begin
            case (state)
                S_SCAN: begin
                    if (all_drained) begin
                        state <= S_IDLE;
                    end else if (take) begin
                        out_req <= 1'b1;
                        last_q  <= word_next.last;
                        state   <= S_REQ;
                    end else if (stat[idx].drained) begin
                        idx <= idx + 1'b1;            // skip an empty reader
                    end
                end
                S_REQ: begin
                    if (out_ack) begin
                        out_req <= 1'b0;
                        state   <= S_ACK_LOW;
                    end
                end
                S_ACK_LOW: begin
                    if (!out_ack) begin
                        state <= last_q ? S_IDLE : S_SCAN;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // payload registers, held through the handshake
    always_ff @(posedge clk) begin
        if (load) begin
            bx_q <= bx;                               // sequencer updated bx with load
        end
        if (take) begin
            out_word <= word_next;
        end
    end

endmodule

/* design/mem_reader.sv */
module mem_reader (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           load,         // new event, latch count
    input  proj_readout_pkg::count_t       item_count,   // words to read this event
    output proj_readout_pkg::mem_rd_t      mem_rd,       // read request to the memory
    input  proj_readout_pkg::proj_word_t   mem_data,     // returned one cycle after en
    input  logic                           pop,          // merger takes the buffered word
    output proj_readout_pkg::reader_stat_t stat,         // buffer and progress flags
    output proj_readout_pkg::proj_word_t   buf_word      // prefetched word
);
    import proj_readout_pkg::*;

    count_t            remaining;   // reads still to issue
    logic [ADDR_W-1:0] addr;        // next read address
    logic              pending;     // read issued last cycle, data on mem_data now
    logic              buf_valid;   // prefetch buffer occupied
    logic              rd_en;       // issue a read this cycle
    proj_word_t        buf_q;       // prefetch buffer

    //////////////////////////////////////////////////////////////////////
    // read issue
    //////////////////////////////////////////////////////////////////////

    // one word may be in flight or buffered, never both, so a read only
    // goes out when nothing is pending and the buffer is empty or leaving
    assign rd_en = !load &&
                   (remaining != '0) &&
                   !pending &&
                   (!buf_valid || pop);

    assign mem_rd.en   = rd_en;
    assign mem_rd.addr = addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            remaining <= '0;
            addr      <= '0;
            pending   <= 1'b0;
            buf_valid <= 1'b0;
        end else if (load) begin
            remaining <= item_count;           // counts above depth are not clipped
            addr      <= '0;                   // walk from the bottom of the memory
            pending   <= 1'b0;
            buf_valid <= 1'b0;
        end else begin
            pending <= rd_en;
            if (rd_en) begin
                remaining <= remaining - 1'b1;
                addr      <= addr + 1'b1;
            end
            if (pending) begin
                buf_valid <= 1'b1;             // returned word lands in the buffer
            end else if (pop) begin
                buf_valid <= 1'b0;             // freed the cycle after the pop
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // prefetch buffer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (pending) begin
            buf_q <= mem_data;                 // capture memory output
        end
    end

    assign buf_word = buf_q;

    //////////////////////////////////////////////////////////////////////
    // status to the merger
    //////////////////////////////////////////////////////////////////////

    assign stat.valid    = buf_valid;
    assign stat.is_final = buf_valid && (remaining == '0);   // no more reads behind it
    assign stat.drained  = !buf_valid && !pending && (remaining == '0);

endmodule

/* design/bx_sequencer.sv */
module bx_sequencer (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              event_start,       // one-cycle start request
    input  logic                              all_drained_done,  // merger finished the event
    output logic                              load,              // readout kick, one cycle
    output logic [proj_readout_pkg::BX_W-1:0] bx,                // bx of the running event
    output logic                              done               // event complete pulse
);
    import proj_readout_pkg::*;

    logic            busy;      // readout in progress
    logic            started;   // at least one event accepted since reset
    logic            accept;    // start taken this cycle
    logic [BX_W-1:0] bx_next;   // bx for the event being accepted

    assign accept  = event_start && !busy;          // starts while busy are dropped
    assign bx_next = started ? bx + 1'b1 : bx;      // first event keeps bx 0

    //////////////////////////////////////////////////////////////////////
    // event acceptance and busy tracking
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            started <= 1'b0;
            load    <= 1'b0;
            bx      <= '0;
            done    <= 1'b0;
        end else begin
            load <= accept;                         // load one cycle after the start
            done <= busy && all_drained_done;       // forward completion

            if (accept) begin
                busy    <= 1'b1;
                started <= 1'b1;
                bx      <= bx_next;                 // wraps mod 8
            end else if (all_drained_done) begin
                busy <= 1'b0;                       // idle again while done is high
            end
        end
    end

endmodule

/* design/proj_readout_pkg.sv */
package proj_readout_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths and depth
    //////////////////////////////////////////////////////////////////////

    localparam int PROJ_W         = 44;    // one projection word
    localparam int ADDR_W         = 5;     // projection memory address
    localparam int MEM_DEPTH      = 32;    // words per projection memory
    localparam int COUNT_W        = 6;     // wide enough to hold a full memory
    localparam int BX_W           = 3;     // bunch crossing number, wraps mod 8
    localparam int SLOTS_PER_PAIR = 4;     // memories per layer pair
    localparam int PAIR_W         = 2;     // layer pair field in the header
    localparam int SLOT_W         = 2;     // slot field in the header
    localparam int SPARE_W        = 2;     // unused header bits, sent as zero

    //////////////////////////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////////////////////////

    typedef logic [COUNT_W-1:0] count_t;   // items in one memory for one event

    typedef struct packed {
        logic [PROJ_W-1:0] data;           // raw projection
    } proj_word_t;

    typedef struct packed {
        logic              en;             // read strobe, data one cycle later
        logic [ADDR_W-1:0] addr;           // word address
    } mem_rd_t;

    typedef struct packed {
        logic valid;                       // prefetch buffer holds a word
        logic is_final;                    // buffered word is the memory's last
        logic drained;                     // nothing left for this event
    } reader_stat_t;

    typedef struct packed {
        logic              last;           // final word of the event
        logic [BX_W-1:0]   bx;             // event bx
        logic [PAIR_W-1:0] pair;           // 0 L1L2, 1 L3L4, 2 L5L6
        logic [SLOT_W-1:0] slot;           // memory within the pair
        logic [SPARE_W-1:0] spare;         // zero
        logic [PROJ_W-1:0] data;           // projection payload
    } proj_out_t;                          // 54 bits on the output link

endpackage
